/* exu_top.f */
source/exu_isa_pkg.sv
source/exu_pipe_pkg.sv
source/exu_stage_if.sv
source/exu_operand_sel.sv
source/exu_alu.sv
source/exu_execute.sv
source/exu_commit.sv
source/exu_top.sv
verification/exu_tb_clk.sv
verification/exu_tb.sv

/* Bender.yml */
package:
  name: exu

dependencies: {}

sources:
  - source/exu_isa_pkg.sv
  - source/exu_pipe_pkg.sv
  - source/exu_stage_if.sv
  - source/exu_operand_sel.sv
  - source/exu_alu.sv
  - source/exu_execute.sv
  - source/exu_commit.sv
  - source/exu_top.sv
  - target: test
    files:
      - verification/exu_tb_clk.sv
      - verification/exu_tb.sv

/* verification/exu_tb.sv */
`timescale 1ns/10ps

module exu_tb;

  localparam int NUM_DIRECTED = 7;
  localparam int NUM_RANDOM   = 400;
  localparam int NUM_INSTR    = NUM_DIRECTED + NUM_RANDOM;
  localparam int QUIET_CYCLES = 4;   // idle window checked after reset
  localparam int DRAIN_CYCLES = 8;
  localparam int MAX_IDLE     = NUM_RANDOM + 3 + QUIET_CYCLES + 1;  // worst case gaps
  localparam int CYCLE_LIMIT  = NUM_INSTR + MAX_IDLE + 20;
  localparam logic [exu_isa_pkg::XLEN-1:0] SIGN_BIT = {1'b1, {(exu_isa_pkg::XLEN-1){1'b0}}};

  typedef struct packed {
    logic [exu_isa_pkg::XLEN-1:0]      pc;
    logic [exu_isa_pkg::XLEN-1:0]      rs1;
    logic [exu_isa_pkg::XLEN-1:0]      rs2;
    logic [exu_isa_pkg::XLEN-1:0]      imm;
    logic [exu_isa_pkg::XLEN-1:0]      csr_data;
    exu_isa_pkg::exc_op_e              exc_op;
    exu_isa_pkg::alu_op_e              alu_op;
    exu_isa_pkg::csr_op_e              csr_op;
    logic [exu_isa_pkg::CSR_IMM_W-1:0] csr_imm;
    logic                              csr_use_imm;
    logic                              pdt_taken;
  } instr_t;

  logic                              clk;
  logic                              rst_i;
  logic                              in_valid_i;
  logic [exu_isa_pkg::XLEN-1:0]      pc_i;
  logic [exu_isa_pkg::XLEN-1:0]      rs1_i;
  logic [exu_isa_pkg::XLEN-1:0]      rs2_i;
  logic [exu_isa_pkg::XLEN-1:0]      imm_i;
  exu_isa_pkg::exc_op_e              exc_op_i;
  exu_isa_pkg::alu_op_e              alu_op_i;
  exu_isa_pkg::csr_op_e              csr_op_i;
  logic [exu_isa_pkg::XLEN-1:0]      csr_data_i;
  logic [exu_isa_pkg::CSR_IMM_W-1:0] csr_imm_i;
  logic                              csr_use_imm_i;
  logic                              pdt_taken_i;
  logic                              out_valid_o;
  logic [exu_isa_pkg::XLEN-1:0]      rd_data_o;
  logic                              csr_wr_valid_o;
  logic [exu_isa_pkg::XLEN-1:0]      csr_wr_data_o;
  logic                              branch_valid_o;
  logic                              branch_taken_o;
  exu_pipe_pkg::jump_type_e          jump_type_o;
  logic                              pdt_correct_o;
  logic                              redirect_valid_o;
  logic [exu_isa_pkg::XLEN-1:0]      redirect_pc_o;

  exu_pipe_pkg::commit_t exp_q[$];
  int                    stamp_q[$];  // rising edge that sampled each strobe
  exu_pipe_pkg::commit_t exp_res;
  int                    exp_stamp;
  int                    seed;
  int                    cycle_count;
  int                    value_errors;
  int                    protocol_errors;

  exu_tb_clk exu_tb_clk_inst (
    .clk_o (clk),
    .rst_o (rst_i)
  );

  exu_top exu_top_inst (
    .clk              (clk),
    .rst_i            (rst_i),
    .in_valid_i       (in_valid_i),
    .pc_i             (pc_i),
    .rs1_i            (rs1_i),
    .rs2_i            (rs2_i),
    .imm_i            (imm_i),
    .exc_op_i         (exc_op_i),
    .alu_op_i         (alu_op_i),
    .csr_op_i         (csr_op_i),
    .csr_data_i       (csr_data_i),
    .csr_imm_i        (csr_imm_i),
    .csr_use_imm_i    (csr_use_imm_i),
    .pdt_taken_i      (pdt_taken_i),
    .out_valid_o      (out_valid_o),
    .rd_data_o        (rd_data_o),
    .csr_wr_valid_o   (csr_wr_valid_o),
    .csr_wr_data_o    (csr_wr_data_o),
    .branch_valid_o   (branch_valid_o),
    .branch_taken_o   (branch_taken_o),
    .jump_type_o      (jump_type_o),
    .pdt_correct_o    (pdt_correct_o),
    .redirect_valid_o (redirect_valid_o),
    .redirect_pc_o    (redirect_pc_o)
  );

  // expected stage result, straight from the RV32I and execute rules
  function automatic exu_pipe_pkg::commit_t ref_result(input instr_t ins);
    exu_pipe_pkg::commit_t        r;
    logic [exu_isa_pkg::XLEN-1:0] a;
    logic [exu_isa_pkg::XLEN-1:0] b;
    logic [exu_isa_pkg::XLEN-1:0] upper;
    logic [exu_isa_pkg::XLEN-1:0] src;
    logic [4:0]                   sh;
    logic                         slt;
    logic                         cmp;
    logic                         taken;
    r     = '0;
    a     = '0;
    b     = '0;
    cmp   = 1'b0;
    upper = ins.imm & 32'hffff_f000;
    case (ins.exc_op)
      exu_isa_pkg::EXC_OPREG, exu_isa_pkg::EXC_BRANCH: begin
        a = ins.rs1;
        b = ins.rs2;
      end
      exu_isa_pkg::EXC_OPIMM, exu_isa_pkg::EXC_LOAD, exu_isa_pkg::EXC_STORE: begin
        a = ins.rs1;
        b = ins.imm;
      end
      exu_isa_pkg::EXC_JAL, exu_isa_pkg::EXC_JALR: begin
        a = ins.pc;
        b = 4;
      end
      exu_isa_pkg::EXC_AUIPC: begin
        a = ins.pc;
        b = upper;
      end
      exu_isa_pkg::EXC_LUI: b = upper;
      exu_isa_pkg::EXC_CSR: b = ins.csr_data;
      default: ;
    endcase
    sh  = b[4:0];
    slt = (a ^ SIGN_BIT) < (b ^ SIGN_BIT);  // signed compare via sign flip
    case (ins.alu_op)
      exu_isa_pkg::ALU_ADD:  r.rd_data = a + b;
      exu_isa_pkg::ALU_SUB:  r.rd_data = a - b;
      exu_isa_pkg::ALU_SLL:  r.rd_data = a << sh;
      exu_isa_pkg::ALU_SLT:  r.rd_data = slt ? 1 : 0;
      exu_isa_pkg::ALU_SLTU: r.rd_data = (a < b) ? 1 : 0;
      exu_isa_pkg::ALU_XOR:  r.rd_data = a ^ b;
      exu_isa_pkg::ALU_SRL:  r.rd_data = a >> sh;
      exu_isa_pkg::ALU_SRA:  r.rd_data = (a >> sh) | (a[31] ? ~(32'hffff_ffff >> sh) : 32'h0);
      exu_isa_pkg::ALU_OR:   r.rd_data = a | b;
      exu_isa_pkg::ALU_AND:  r.rd_data = a & b;
      exu_isa_pkg::ALU_BEQ:  cmp = (a == b);
      exu_isa_pkg::ALU_BNE:  cmp = (a != b);
      exu_isa_pkg::ALU_BLT:  cmp = slt;
      exu_isa_pkg::ALU_BGE:  cmp = !slt;
      exu_isa_pkg::ALU_BLTU: cmp = (a < b);
      exu_isa_pkg::ALU_BGEU: cmp = (a >= b);
      default: ;
    endcase
    src = ins.csr_use_imm ? exu_isa_pkg::XLEN'(ins.csr_imm) : ins.rs1;
    case (ins.csr_op)
      exu_isa_pkg::CSR_RW: begin
        r.csr_wr_data  = src;
        r.csr_wr_valid = 1'b1;
      end
      exu_isa_pkg::CSR_RS: begin
        r.csr_wr_data  = ins.csr_data | src;
        r.csr_wr_valid = (src != 0);
      end
      exu_isa_pkg::CSR_RC: begin
        r.csr_wr_data  = ins.csr_data & ~src;
        r.csr_wr_valid = (src != 0);
      end
      default: ;
    endcase
    case (ins.exc_op)
      exu_isa_pkg::EXC_JAL:    r.jump_type = exu_pipe_pkg::JUMP_JAL;
      exu_isa_pkg::EXC_JALR:   r.jump_type = exu_pipe_pkg::JUMP_JALR;
      exu_isa_pkg::EXC_BRANCH: r.jump_type = exu_pipe_pkg::JUMP_BRANCH;
      default:                 r.jump_type = exu_pipe_pkg::JUMP_NONE;
    endcase
    taken = (ins.exc_op == exu_isa_pkg::EXC_BRANCH) ? cmp :
            (r.jump_type != exu_pipe_pkg::JUMP_NONE);
    r.branch_valid   = (r.jump_type != exu_pipe_pkg::JUMP_NONE);
    r.branch_taken   = taken;
    r.pdt_correct    = (taken == ins.pdt_taken);
    r.redirect_valid = (taken != ins.pdt_taken);
    if (!taken) r.redirect_pc = ins.pc + 4;  // only seen when predicted taken
    else if (ins.exc_op == exu_isa_pkg::EXC_JALR) r.redirect_pc = (ins.rs1 + ins.imm) & ~32'h1;
    else r.redirect_pc = ins.pc + ins.imm;
    return r;
  endfunction

  task automatic check_data(input logic [exu_isa_pkg::XLEN-1:0] got,
                            input logic [exu_isa_pkg::XLEN-1:0] exp, input string what);
    if (got !== exp) begin
      value_errors++;
      $display("** Error at %0t: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_flag(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      value_errors++;
      $display("** Error at %0t: %s is %b, expected %b", $time, what, got, exp);
    end
  endtask

  task automatic check_jump(input exu_pipe_pkg::jump_type_e got,
                            input exu_pipe_pkg::jump_type_e exp, input string what);
    if (got !== exp) begin
      value_errors++;
      $display("** Error at %0t: %s is %s, expected %s", $time, what, got.name(), exp.name());
    end
  endtask

  function automatic instr_t base_instr(input exu_isa_pkg::exc_op_e cls);
    instr_t ins;
    ins             = '0;
    ins.pc          = 32'h0000_1000;
    ins.rs1         = 32'h0000_2001;
    ins.rs2         = 32'h0000_0077;
    ins.imm         = 32'h0000_0010;
    ins.csr_data    = 32'ha5a5_0f0f;
    ins.exc_op      = cls;
    ins.alu_op      = exu_isa_pkg::ALU_ADD;
    ins.csr_op      = exu_isa_pkg::CSR_NONE;
    return ins;
  endfunction

  task automatic make_random(output instr_t ins);
    logic [31:0] rnd;
    int          pick;
    ins          = base_instr(exu_isa_pkg::EXC_NONE);
    rnd          = $random(seed);
    ins.pc       = rnd & 32'hffff_fffc;  // word aligned
    ins.rs1      = $random(seed);
    ins.rs2      = $random(seed);
    ins.imm      = $random(seed);
    ins.csr_data = $random(seed);
    rnd          = $random(seed);
    ins.csr_imm     = rnd[4:0];
    ins.csr_use_imm = rnd[8];
    ins.pdt_taken   = rnd[12];
    pick       = $unsigned($random(seed)) % 11;
    ins.exc_op = exu_isa_pkg::exc_op_e'(pick);
    case (ins.exc_op)
      exu_isa_pkg::EXC_OPREG, exu_isa_pkg::EXC_OPIMM: begin
        pick       = $unsigned($random(seed)) % 10;
        ins.alu_op = exu_isa_pkg::alu_op_e'(pick);
      end
      exu_isa_pkg::EXC_BRANCH: begin
        pick       = 16 + $unsigned($random(seed)) % 6;
        ins.alu_op = exu_isa_pkg::alu_op_e'(pick);
        if (rnd[17:16] == 2'b00) ins.rs2 = ins.rs1;  // hit the equal case
      end
      exu_isa_pkg::EXC_CSR: begin
        pick       = 1 + $unsigned($random(seed)) % 3;
        ins.csr_op = exu_isa_pkg::csr_op_e'(pick);
        if (rnd[21:20] == 2'b00) begin
          ins.rs1     = '0;
          ins.csr_imm = '0;
        end
      end
      default: ;
    endcase
  endtask

  task automatic issue_instr(input instr_t ins);
    @(negedge clk);
    in_valid_i    = 1'b1;
    pc_i          = ins.pc;
    rs1_i         = ins.rs1;
    rs2_i         = ins.rs2;
    imm_i         = ins.imm;
    exc_op_i      = ins.exc_op;
    alu_op_i      = ins.alu_op;
    csr_op_i      = ins.csr_op;
    csr_data_i    = ins.csr_data;
    csr_imm_i     = ins.csr_imm;
    csr_use_imm_i = ins.csr_use_imm;
    pdt_taken_i   = ins.pdt_taken;
    exp_q.push_back(ref_result(ins));
    stamp_q.push_back(cycle_count + 1);  // sampled at the coming rising edge
  endtask

  task automatic idle_cycle();
    @(negedge clk);
    in_valid_i = 1'b0;
  endtask

  // compares on every rising edge, also keeps the cycle budget
  always @(posedge clk) begin
    cycle_count = cycle_count + 1;
    if (cycle_count > CYCLE_LIMIT) begin
      $display("timeout: run went past %0d cycles", CYCLE_LIMIT);
      $display("Simulation failed");
      $finish;
    end else if (out_valid_o === 1'b1) begin
      if (exp_q.size() == 0) begin
        protocol_errors++;
        $display("out_valid_o went high at %0t with no instruction outstanding", $time);
      end else begin
        exp_res   = exp_q.pop_front();
        exp_stamp = stamp_q.pop_front();
        // valid rises at edge N+1 and is sampled here at edge N+2
        if (cycle_count != exp_stamp + 2) begin
          protocol_errors++;
          $display("result at %0t came %0d cycles after its strobe instead of 2",
                   $time, cycle_count - exp_stamp);
        end
        check_data(rd_data_o, exp_res.rd_data, "rd_data_o");
        check_flag(csr_wr_valid_o, exp_res.csr_wr_valid, "csr_wr_valid_o");
        if (exp_res.csr_wr_valid) check_data(csr_wr_data_o, exp_res.csr_wr_data, "csr_wr_data_o");
        check_flag(branch_valid_o, exp_res.branch_valid, "branch_valid_o");
        check_flag(branch_taken_o, exp_res.branch_taken, "branch_taken_o");
        check_jump(jump_type_o, exp_res.jump_type, "jump_type_o");
        check_flag(pdt_correct_o, exp_res.pdt_correct, "pdt_correct_o");
        check_flag(redirect_valid_o, exp_res.redirect_valid, "redirect_valid_o");
        if (exp_res.redirect_valid) check_data(redirect_pc_o, exp_res.redirect_pc, "redirect_pc_o");
      end
    end
  end

  initial begin
    instr_t ins;
    seed            = 32'hd1e02599;
    cycle_count     = 0;
    value_errors    = 0;
    protocol_errors = 0;
    in_valid_i      = 1'b0;
    pc_i            = '0;
    rs1_i           = '0;
    rs2_i           = '0;
    imm_i           = '0;
    exc_op_i        = exu_isa_pkg::EXC_NONE;
    alu_op_i        = exu_isa_pkg::ALU_ADD;
    csr_op_i        = exu_isa_pkg::CSR_NONE;
    csr_data_i      = '0;
    csr_imm_i       = '0;
    csr_use_imm_i   = 1'b0;
    pdt_taken_i     = 1'b0;

    wait (rst_i == 1'b0);
    repeat (QUIET_CYCLES) begin
      @(negedge clk);
      check_flag(out_valid_o, 1'b0, "out_valid_o after reset");
      check_flag(csr_wr_valid_o, 1'b0, "csr_wr_valid_o after reset");
      check_flag(branch_valid_o, 1'b0, "branch_valid_o after reset");
      check_flag(redirect_valid_o, 1'b0, "redirect_valid_o after reset");
    end

    // directed corner cases, issued back to back
    ins = base_instr(exu_isa_pkg::EXC_JALR);
    ins.imm = 32'h0000_0006;  // odd target, bit 0 must clear
    issue_instr(ins);
    ins = base_instr(exu_isa_pkg::EXC_JAL);
    ins.pdt_taken = 1'b1;
    issue_instr(ins);
    ins = base_instr(exu_isa_pkg::EXC_NONE);
    ins.pdt_taken = 1'b1;
    issue_instr(ins);
    ins = base_instr(exu_isa_pkg::EXC_CSR);
    ins.csr_op      = exu_isa_pkg::CSR_RS;
    ins.csr_use_imm = 1'b1;  // zero immediate, no write
    issue_instr(ins);
    ins = base_instr(exu_isa_pkg::EXC_CSR);
    ins.csr_op = exu_isa_pkg::CSR_RC;
    ins.rs1    = '0;
    issue_instr(ins);
    ins = base_instr(exu_isa_pkg::EXC_CSR);
    ins.csr_op      = exu_isa_pkg::CSR_RW;
    ins.csr_use_imm = 1'b1;
    ins.csr_imm     = 5'h1f;
    issue_instr(ins);
    ins = base_instr(exu_isa_pkg::EXC_LUI);
    ins.imm = 32'hdead_beef;
    issue_instr(ins);

    for (int i = 0; i < NUM_RANDOM; i++) begin
      make_random(ins);
      issue_instr(ins);
      if (($unsigned($random(seed)) % 4) == 0) idle_cycle();
    end
    idle_cycle();

    for (int i = 0; i < DRAIN_CYCLES && exp_q.size() != 0; i++) @(posedge clk);
    repeat (2) @(negedge clk);  // catch stray valids
    if (exp_q.size() != 0) begin
      protocol_errors++;
      $display("%0d issued instructions never produced a result", exp_q.size());
    end
    $display("errors: %0d value mismatches, %0d protocol problems",
             value_errors, protocol_errors);
    if (value_errors == 0 && protocol_errors == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

/* verification/exu_tb_clk.sv */
`timescale 1ns/10ps

module exu_tb_clk (
  output logic clk_o,
  output logic rst_o
);

  localparam time HALF_PERIOD = 50;  // 100 ns clock

  initial begin
    clk_o = 1'b0;
    forever #(HALF_PERIOD) clk_o = ~clk_o;
  end

  // released on a falling edge after three rising edges
  initial begin
    rst_o = 1'b1;
    repeat (3) @(negedge clk_o);
    rst_o = 1'b0;
  end

endmodule

/* source/exu_top.sv */
`timescale 1ns/10ps

module exu_top (
  input  logic                              clk,
  input  logic                              rst_i,
  input  logic                              in_valid_i,
  input  logic [exu_isa_pkg::XLEN-1:0]      pc_i,
  input  logic [exu_isa_pkg::XLEN-1:0]      rs1_i,
  input  logic [exu_isa_pkg::XLEN-1:0]      rs2_i,
  input  logic [exu_isa_pkg::XLEN-1:0]      imm_i,
  input  exu_isa_pkg::exc_op_e              exc_op_i,
  input  exu_isa_pkg::alu_op_e              alu_op_i,
  input  exu_isa_pkg::csr_op_e              csr_op_i,
  input  logic [exu_isa_pkg::XLEN-1:0]      csr_data_i,
  input  logic [exu_isa_pkg::CSR_IMM_W-1:0] csr_imm_i,
  input  logic                              csr_use_imm_i,
  input  logic                              pdt_taken_i,
  output logic                              out_valid_o,
  output logic [exu_isa_pkg::XLEN-1:0]      rd_data_o,
  output logic                              csr_wr_valid_o,
  output logic [exu_isa_pkg::XLEN-1:0]      csr_wr_data_o,
  output logic                              branch_valid_o,
  output logic                              branch_taken_o,
  output exu_pipe_pkg::jump_type_e          jump_type_o,
  output logic                              pdt_correct_o,
  output logic                              redirect_valid_o,
  output logic [exu_isa_pkg::XLEN-1:0]      redirect_pc_o
);

  exu_issue_if           issue ();
  exu_result_if          result ();
  exu_pipe_pkg::commit_t res_q;

  exu_operand_sel exu_operand_sel_inst (
    .clk           (clk),
    .rst_i         (rst_i),
    .in_valid_i    (in_valid_i),
    .pc_i          (pc_i),
    .rs1_i         (rs1_i),
    .rs2_i         (rs2_i),
    .imm_i         (imm_i),
    .exc_op_i      (exc_op_i),
    .alu_op_i      (alu_op_i),
    .csr_op_i      (csr_op_i),
    .csr_data_i    (csr_data_i),
    .csr_imm_i     (csr_imm_i),
    .csr_use_imm_i (csr_use_imm_i),
    .pdt_taken_i   (pdt_taken_i),
    .issue         (issue.src)
  );

  exu_execute exu_execute_inst (
    .issue  (issue.dst),
    .result (result.src)
  );

  exu_commit exu_commit_inst (
    .clk         (clk),
    .rst_i       (rst_i),
    .result      (result.dst),
    .out_valid_o (out_valid_o),
    .res_o       (res_q)
  );

  // flatten the commit record onto the output pins
  assign rd_data_o        = res_q.rd_data;
  assign csr_wr_valid_o   = res_q.csr_wr_valid;
  assign csr_wr_data_o    = res_q.csr_wr_data;
  assign branch_valid_o   = res_q.branch_valid;
  assign branch_taken_o   = res_q.branch_taken;
  assign jump_type_o      = res_q.jump_type;
  assign pdt_correct_o    = res_q.pdt_correct;
  assign redirect_valid_o = res_q.redirect_valid;
  assign redirect_pc_o    = res_q.redirect_pc;

endmodule

/* source/exu_commit.sv */
`timescale 1ns/10ps

module exu_commit (
  input  logic                  clk,
  input  logic                  rst_i,
  exu_result_if.dst             result,
  output logic                  out_valid_o,
  output exu_pipe_pkg::commit_t res_o
);

  always_ff @(posedge clk) begin
    if (rst_i) begin
      out_valid_o <= 1'b0;
    end else begin
      out_valid_o <= result.valid;
    end
  end

  // record holds until the next valid result
  always_ff @(posedge clk) begin
    if (rst_i) begin
      res_o.csr_wr_valid   <= 1'b0;  // no stale csr write
      res_o.branch_valid   <= 1'b0;
      res_o.redirect_valid <= 1'b0;  // no stale redirect
    end else if (result.valid) begin
      res_o <= result.res;
    end
  end

endmodule

/* source/exu_execute.sv */
`timescale 1ns/10ps

module exu_execute (
  exu_issue_if.dst  issue,
  exu_result_if.src result
);

  logic [exu_isa_pkg::XLEN-1:0] alu_res;
  logic                         alu_cmp;
  logic [exu_isa_pkg::XLEN-1:0] csr_src;
  logic                         is_jal;
  logic                         is_jalr;
  logic                         is_branch;
  logic                         taken;
  logic [exu_isa_pkg::XLEN-1:0] jalr_sum;
  exu_pipe_pkg::commit_t        res_d;

  exu_alu exu_alu_inst (
    .a_i      (issue.alu_a),
    .b_i      (issue.alu_b),
    .op_i     (issue.alu_op),
    .result_o (alu_res),
    .cmp_o    (alu_cmp)
  );

  assign csr_src = issue.csr_use_imm ?
                   {{(exu_isa_pkg::XLEN-exu_isa_pkg::CSR_IMM_W){1'b0}}, issue.csr_imm} :
                   issue.rs1;

  assign is_jal    = (issue.exc_op == exu_isa_pkg::EXC_JAL);
  assign is_jalr   = (issue.exc_op == exu_isa_pkg::EXC_JALR);
  assign is_branch = (issue.exc_op == exu_isa_pkg::EXC_BRANCH);
  assign taken     = (is_branch & alu_cmp) | is_jal | is_jalr;
  assign jalr_sum  = issue.rs1 + issue.imm;

  always_comb begin
    res_d = '0;
    res_d.rd_data = alu_res;

    // csr rmw, set/clear with a zero source must not write
    case (issue.csr_op)
      exu_isa_pkg::CSR_RW: begin
        res_d.csr_wr_data  = csr_src;
        res_d.csr_wr_valid = 1'b1;
      end
      exu_isa_pkg::CSR_RS: begin
        res_d.csr_wr_data  = issue.csr_data | csr_src;
        res_d.csr_wr_valid = |csr_src;
      end
      exu_isa_pkg::CSR_RC: begin
        res_d.csr_wr_data  = issue.csr_data & ~csr_src;
        res_d.csr_wr_valid = |csr_src;
      end
      default: ;
    endcase

    res_d.branch_valid = is_jal | is_jalr | is_branch;
    res_d.branch_taken = taken;
    if (is_jal)         res_d.jump_type = exu_pipe_pkg::JUMP_JAL;
    else if (is_jalr)   res_d.jump_type = exu_pipe_pkg::JUMP_JALR;
    else if (is_branch) res_d.jump_type = exu_pipe_pkg::JUMP_BRANCH;
    else                res_d.jump_type = exu_pipe_pkg::JUMP_NONE;

    res_d.pdt_correct    = (taken == issue.pdt_taken);
    res_d.redirect_valid = (taken != issue.pdt_taken);  // mispredict

    if (issue.pdt_taken && !taken) begin
      res_d.redirect_pc = issue.pc + exu_isa_pkg::XLEN'(4);  // fall through
    end else if (is_jalr) begin
      res_d.redirect_pc = {jalr_sum[exu_isa_pkg::XLEN-1:1], 1'b0};
    end else begin
      res_d.redirect_pc = issue.pc + issue.imm;
    end
  end

  assign result.valid = issue.valid;
  assign result.res   = res_d;

endmodule

/* source/exu_alu.sv */
`timescale 1ns/10ps

module exu_alu (
  input  logic [exu_isa_pkg::XLEN-1:0] a_i,
  input  logic [exu_isa_pkg::XLEN-1:0] b_i,
  input  exu_isa_pkg::alu_op_e         op_i,
  output logic [exu_isa_pkg::XLEN-1:0] result_o,
  output logic                         cmp_o
);

  logic [exu_isa_pkg::SHAMT_W-1:0] shamt;
  logic                            eq;
  logic                            lt_s;
  logic                            lt_u;

  assign shamt = b_i[exu_isa_pkg::SHAMT_W-1:0];

  // comparator shared by slt* and branches
  assign eq   = (a_i == b_i);
  assign lt_s = ($signed(a_i) < $signed(b_i));
  assign lt_u = (a_i < b_i);

  always_comb begin
    result_o = '0;
    case (op_i)
      exu_isa_pkg::ALU_ADD:  result_o = a_i + b_i;
      exu_isa_pkg::ALU_SUB:  result_o = a_i - b_i;
      exu_isa_pkg::ALU_SLL:  result_o = a_i << shamt;
      exu_isa_pkg::ALU_SLT:  result_o = {{(exu_isa_pkg::XLEN-1){1'b0}}, lt_s};
      exu_isa_pkg::ALU_SLTU: result_o = {{(exu_isa_pkg::XLEN-1){1'b0}}, lt_u};
      exu_isa_pkg::ALU_XOR:  result_o = a_i ^ b_i;
      exu_isa_pkg::ALU_SRL:  result_o = a_i >> shamt;
      exu_isa_pkg::ALU_SRA:  result_o = $unsigned($signed(a_i) >>> shamt);
      exu_isa_pkg::ALU_OR:   result_o = a_i | b_i;
      exu_isa_pkg::ALU_AND:  result_o = a_i & b_i;
      default:               result_o = '0;  // compare ops leave rd at zero
    endcase
  end

  always_comb begin
    case (op_i)
      exu_isa_pkg::ALU_BEQ:  cmp_o = eq;
      exu_isa_pkg::ALU_BNE:  cmp_o = ~eq;
      exu_isa_pkg::ALU_BLT:  cmp_o = lt_s;
      exu_isa_pkg::ALU_BGE:  cmp_o = ~lt_s;
      exu_isa_pkg::ALU_BLTU: cmp_o = lt_u;
      exu_isa_pkg::ALU_BGEU: cmp_o = ~lt_u;
      default:               cmp_o = 1'b0;
    endcase
  end

endmodule

/* source/exu_operand_sel.sv */
`timescale 1ns/10ps

module exu_operand_sel (
  input  logic                              clk,
  input  logic                              rst_i,
  input  logic                              in_valid_i,
  input  logic [exu_isa_pkg::XLEN-1:0]      pc_i,
  input  logic [exu_isa_pkg::XLEN-1:0]      rs1_i,
  input  logic [exu_isa_pkg::XLEN-1:0]      rs2_i,
  input  logic [exu_isa_pkg::XLEN-1:0]      imm_i,
  input  exu_isa_pkg::exc_op_e              exc_op_i,
  input  exu_isa_pkg::alu_op_e              alu_op_i,
  input  exu_isa_pkg::csr_op_e              csr_op_i,
  input  logic [exu_isa_pkg::XLEN-1:0]      csr_data_i,
  input  logic [exu_isa_pkg::CSR_IMM_W-1:0] csr_imm_i,
  input  logic                              csr_use_imm_i,
  input  logic                              pdt_taken_i,
  exu_issue_if.src                          issue
);

  logic [exu_isa_pkg::XLEN-1:0] upper_imm;
  logic [exu_isa_pkg::XLEN-1:0] sel_a;
  logic [exu_isa_pkg::XLEN-1:0] sel_b;

  always_ff @(posedge clk) begin
    if (rst_i) begin
      issue.valid <= 1'b0;
    end else begin
      issue.valid <= in_valid_i;
    end
  end

  // payload only moves on a strobe
  always_ff @(posedge clk) begin
    if (in_valid_i) begin
      issue.pc          <= pc_i;
      issue.rs1         <= rs1_i;
      issue.rs2         <= rs2_i;
      issue.imm         <= imm_i;
      issue.alu_op      <= alu_op_i;
      issue.exc_op      <= exc_op_i;
      issue.csr_op      <= csr_op_i;
      issue.csr_data    <= csr_data_i;
      issue.csr_imm     <= csr_imm_i;
      issue.csr_use_imm <= csr_use_imm_i;
      issue.pdt_taken   <= pdt_taken_i;
    end
  end

  assign upper_imm = {issue.imm[exu_isa_pkg::XLEN-1:12], 12'b0};  // lui/auipc

  always_comb begin
    sel_a = '0;
    sel_b = '0;
    case (issue.exc_op)
      exu_isa_pkg::EXC_OPREG,
      exu_isa_pkg::EXC_BRANCH: begin
        sel_a = issue.rs1;
        sel_b = issue.rs2;
      end
      exu_isa_pkg::EXC_OPIMM,
      exu_isa_pkg::EXC_LOAD,
      exu_isa_pkg::EXC_STORE: begin
        sel_a = issue.rs1;
        sel_b = issue.imm;
      end
      exu_isa_pkg::EXC_JAL,
      exu_isa_pkg::EXC_JALR: begin
        sel_a = issue.pc;
        sel_b = exu_isa_pkg::XLEN'(4);  // link address
      end
      exu_isa_pkg::EXC_AUIPC: begin
        sel_a = issue.pc;
        sel_b = upper_imm;
      end
      exu_isa_pkg::EXC_LUI: sel_b = upper_imm;
      exu_isa_pkg::EXC_CSR: sel_b = issue.csr_data;  // old csr goes to rd
      default: ;
    endcase
  end

  assign issue.alu_a = sel_a;
  assign issue.alu_b = sel_b;

endmodule

/* source/exu_stage_if.sv */
`timescale 1ns/10ps

// registered instruction plus selected alu operands
interface exu_issue_if;

  logic                                valid;  // one-cycle strobe
  logic [exu_isa_pkg::XLEN-1:0]        pc;
  logic [exu_isa_pkg::XLEN-1:0]        rs1;
  logic [exu_isa_pkg::XLEN-1:0]        rs2;
  logic [exu_isa_pkg::XLEN-1:0]        imm;
  logic [exu_isa_pkg::XLEN-1:0]        alu_a;
  logic [exu_isa_pkg::XLEN-1:0]        alu_b;
  exu_isa_pkg::alu_op_e                alu_op;
  exu_isa_pkg::exc_op_e                exc_op;
  exu_isa_pkg::csr_op_e                csr_op;
  logic [exu_isa_pkg::XLEN-1:0]        csr_data;  // old csr value
  logic [exu_isa_pkg::CSR_IMM_W-1:0]   csr_imm;
  logic                                csr_use_imm;
  logic                                pdt_taken;

  modport src (
    output valid, pc, rs1, rs2, imm, alu_a, alu_b, alu_op, exc_op,
    output csr_op, csr_data, csr_imm, csr_use_imm, pdt_taken
  );

  modport dst (
    input valid, pc, rs1, rs2, imm, alu_a, alu_b, alu_op, exc_op,
    input csr_op, csr_data, csr_imm, csr_use_imm, pdt_taken
  );

endinterface

// execute result on its way to the commit register
interface exu_result_if;

  logic                  valid;
  exu_pipe_pkg::commit_t res;

  modport src (output valid, res);
  modport dst (input valid, res);

endinterface

/* source/exu_pipe_pkg.sv */
package exu_pipe_pkg;

  // reported to the predictor with each resolved jump
  typedef enum logic [1:0] {
    JUMP_NONE   = 2'b00,
    JUMP_JAL    = 2'b01,
    JUMP_JALR   = 2'b10,
    JUMP_BRANCH = 2'b11
  } jump_type_e;

  // everything the stage produces for one instruction
  typedef struct packed {
    logic [exu_isa_pkg::XLEN-1:0] rd_data;
    logic                         csr_wr_valid;
    logic [exu_isa_pkg::XLEN-1:0] csr_wr_data;
    logic                         branch_valid;
    logic                         branch_taken;
    jump_type_e                   jump_type;
    logic                         pdt_correct;  // predicted direction matched
    logic                         redirect_valid;
    logic [exu_isa_pkg::XLEN-1:0] redirect_pc;
  } commit_t;

endpackage

/* source/exu_isa_pkg.sv */
package exu_isa_pkg;

  localparam int XLEN      = 32;
  localparam int SHAMT_W   = 5;  // rv32 shift amount
  localparam int CSR_IMM_W = 5;  // zimm field of csrr*i

  // instruction class, picks operands and branch behaviour
  typedef enum logic [3:0] {
    EXC_NONE   = 4'd0,
    EXC_LUI    = 4'd1,
    EXC_AUIPC  = 4'd2,
    EXC_JAL    = 4'd3,
    EXC_JALR   = 4'd4,
    EXC_BRANCH = 4'd5,
    EXC_OPIMM  = 4'd6,
    EXC_OPREG  = 4'd7,
    EXC_LOAD   = 4'd8,
    EXC_STORE  = 4'd9,
    EXC_CSR    = 4'd10
  } exc_op_e;

  // alu operation
  // codes 0..9 produce a result, 16..21 only drive the comparator
  typedef enum logic [4:0] {
    ALU_ADD  = 5'd0,
    ALU_SUB  = 5'd1,
    ALU_SLL  = 5'd2,
    ALU_SLT  = 5'd3,
    ALU_SLTU = 5'd4,
    ALU_XOR  = 5'd5,
    ALU_SRL  = 5'd6,
    ALU_SRA  = 5'd7,
    ALU_OR   = 5'd8,
    ALU_AND  = 5'd9,
    ALU_BEQ  = 5'd16,
    ALU_BNE  = 5'd17,
    ALU_BLT  = 5'd18,
    ALU_BGE  = 5'd19,
    ALU_BLTU = 5'd20,
    ALU_BGEU = 5'd21
  } alu_op_e;

  // csr read-modify-write kind
  typedef enum logic [1:0] {
    CSR_NONE = 2'd0,
    CSR_RW   = 2'd1,
    CSR_RS   = 2'd2,
    CSR_RC   = 2'd3
  } csr_op_e;

endpackage
